/* files.f */
source/eye_tracker_pkg.sv
source/camera_link_rx.sv
source/centroid_accum.sv
source/result_fifo.sv
source/result_framer.sv
source/uart_tx.sv
source/eye_tracker_top.sv
test/tb_clock.sv
test/eye_tracker_chk.sv
test/eye_tracker_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+1000
TOP       ?= eye_tracker_tb
FILELIST  ?= files.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) $(SIMFLAGS) | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* test/eye_tracker_tb.sv */
module eye_tracker_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import eye_tracker_pkg::*;

    localparam int line_beats     = 16;
    localparam int frame_lines    = 8;
    localparam int line_gap       = 4;
    localparam int frame_gap      = 8;
    localparam int n_frames       = 7;
    // Worst case with every other beat a dval gap
    localparam int frame_cycles   = 4 + frame_lines * (2 * line_beats + line_gap) + frame_gap;
    localparam int result_cycles  = (result_bytes + 1) * uart_frame_bits * uart_clks_per_bit;
    localparam int timeout_cycles = 2 * n_frames * (frame_cycles + result_cycles);

    logic               clk;
    logic               rst_n;
    logic               fval;
    logic               lval;
    logic               dval;
    logic [pixel_w-1:0] data_l;
    logic [pixel_w-1:0] data_r;
    logic [pixel_w-1:0] jp;
    logic               uart_txd;
    logic               overrun;
    int                 seed;
    int                 cycle_cnt = 0;
    int                 overrun_cnt = 0;
    int                 tb_errors = 0;
    logic               timed_out = 1'b0;

    tb_clock clk0 (
        .clk   (clk),
        .rst_n (rst_n)
    );

    eye_tracker_top dut0 (
        .cclk     (clk),
        .rst_n    (rst_n),
        .fval     (fval),
        .lval     (lval),
        .dval     (dval),
        .data_l   (data_l),
        .data_r   (data_r),
        .jp       (jp),
        .uart_txd (uart_txd),
        .overrun  (overrun)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (rst_n && overrun)
            overrun_cnt <= overrun_cnt + 1;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic send_frame(input bit use_gaps);
        int n;
        @(posedge clk);
        fval <= fval_pol;
        repeat (2) @(posedge clk);
        for (int ln = 0; ln < frame_lines; ln++) begin
            n = 0;
            while (n < line_beats) begin
                @(posedge clk);
                lval <= lval_pol;
                if (use_gaps && (($random(seed) & 3) == 0)) begin
                    dval <= !dval_pol;           // Idle beat with noise on the data
                end else begin
                    dval <= dval_pol;
                    n++;
                end
                data_l <= pixel_w'($random(seed));
                data_r <= pixel_w'($random(seed));
            end
            @(posedge clk);
            lval <= !lval_pol;
            dval <= !dval_pol;
            repeat (line_gap - 1) @(posedge clk);
        end
        fval <= !fval_pol;
        repeat (frame_gap) @(posedge clk);
    endtask

    task automatic wait_results;
        repeat (4) @(posedge clk);
        while (dut0.chk0.results_seen != dut0.chk0.results_expected)
            @(posedge clk);
    endtask

    task automatic compare_value(input string what, input int got, input int exp);
        assert (got == exp)
        else begin
            tb_errors++;
            $display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic finish_run;
        int chk_errors;
        chk_errors = dut0.chk0.err_cnt;
        $display("Errors: %0d assertion, %0d testbench, %0d timeout",
                 chk_errors, tb_errors, int'(timed_out));
        if (chk_errors == 0 && tb_errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        seed   = 32'h6d9a;
        fval   = !fval_pol;
        lval   = !lval_pol;
        dval   = !dval_pol;
        data_l = '0;
        data_r = '0;
        jp     = '0;
        @(posedge rst_n);
        repeat (4) @(posedge clk);

        // Threshold 0 so every pixel counts
        send_frame(1'b0);
        wait_results();
        compare_value("pixel count", int'(dut0.chk0.got_word.sums.sum_s),
                      2 * line_beats * frame_lines);
        compare_value("x sum", int'(dut0.chk0.got_word.sums.sum_sx),
                      frame_lines * line_beats * (2 * line_beats - 1));
        compare_value("row sum", int'(dut0.chk0.got_word.sums.sum_sy),
                      line_beats * frame_lines * (frame_lines - 1));

        // Mid-range threshold with dval gaps
        @(posedge clk);
        jp <= 8'h80;
        repeat (3) begin
            send_frame(1'b1);
            wait_results();
        end

        // Back to back so the third frame finds no credit
        repeat (3) send_frame(1'b1);
        wait_results();
        repeat (result_cycles / 4) @(posedge clk);
        compare_value("overrun pulses", overrun_cnt, 1);
        compare_value("results received", dut0.chk0.results_seen, n_frames - 1);
        finish_run();
    end

    initial begin
        while (cycle_cnt < timeout_cycles)
            @(posedge clk);
        $display("Run timed out after %0d cycles with results still missing", cycle_cnt);
        timed_out = 1'b1;
        finish_run();
    end

endmodule

/* test/eye_tracker_chk.sv */
module eye_tracker_chk (
    input  logic                                 cclk,
    input  logic                                 rst_n,
    input  logic                                 fval,
    input  logic                                 lval,
    input  logic                                 dval,
    input  logic [eye_tracker_pkg::pixel_w-1:0]  data_l,
    input  logic [eye_tracker_pkg::pixel_w-1:0]  data_r,
    input  logic [eye_tracker_pkg::pixel_w-1:0]  jp,
    input  logic                                 uart_txd,
    input  logic                                 overrun
);
    timeunit 1ns;
    timeprecision 100ps;
    import eye_tracker_pkg::*;

    localparam int frame_clks = uart_frame_bits * uart_clks_per_bit;
    localparam int half_bit   = uart_clks_per_bit / 2;

    logic              fval_a;
    logic              lval_a;
    logic              pix_ok;
    logic              hit_l;
    logic              hit_r;
    logic              fval_d;
    logic              lval_d;
    logic              frame_end;
    logic              credit_ok;
    logic              miss_now;
    logic              frame_seen;
    int unsigned       m_col;
    int unsigned       m_row;
    int unsigned       m_s;
    int unsigned       m_sx;
    int unsigned       m_sy;
    int                m_credits;
    result_word_u      exp_q[$];
    result_word_u      exp_word;
    result_word_u      got_word;
    logic              exp_avail;
    logic              dec_busy;
    int                dec_cnt;
    logic [7:0]        dec_shift;
    int                byte_pos;       // 0 is the sync byte
    logic              byte_done;
    logic [7:0]        byte_val;
    int                done_pos;
    logic              res_done;
    logic              credit_back;
    int                results_seen;
    int                results_expected;
    int                err_cnt = 0;

    function automatic result_word_u make_word(int unsigned s, int unsigned sx, int unsigned sy);
        result_word_u w;
        w.sums.pad    = '0;
        w.sums.sum_s  = sum_s_w'(s);
        w.sums.sum_sx = sum_sx_w'(sx);
        w.sums.sum_sy = sum_sy_w'(sy);
        return w;
    endfunction

    assign fval_a    = (fval == fval_pol);
    assign lval_a    = (lval == lval_pol);
    assign pix_ok    = fval_a && lval_a && (dval == dval_pol);
    assign hit_l     = pix_ok && (data_l >= jp);
    assign hit_r     = pix_ok && (data_r >= jp);
    assign frame_end = fval_d && !fval_a;

    // Queue entry is freed as the start bit of the last byte goes out
    assign credit_back = !dec_busy && !uart_txd && (byte_pos == result_bytes);
    assign credit_ok   = (m_credits > 0) || credit_back;
    assign miss_now    = frame_end && !credit_ok;

    // ------------------------------------------------------------
    // Reference model of the sums and credits
    // ------------------------------------------------------------
    always @(posedge cclk) begin
        if (!rst_n) begin
            fval_d           <= 1'b0;
            lval_d           <= 1'b0;
            m_col            <= 0;
            m_row            <= 0;
            m_s              <= 0;
            m_sx             <= 0;
            m_sy             <= 0;
            m_credits        <= result_depth;
            frame_seen       <= 1'b0;
            results_expected <= 0;
        end else begin
            fval_d <= fval_a;
            lval_d <= lval_a;
            if (!lval_a)
                m_col <= 0;
            else if (pix_ok)
                m_col <= m_col + 1;
            if (!fval_a)
                m_row <= 0;
            else if (lval_d && !lval_a)
                m_row <= m_row + 1;     // Line ended
            if (frame_end) begin
                frame_seen <= 1'b1;
                if (credit_ok) begin
                    exp_q.push_back(make_word(m_s, m_sx, m_sy));
                    results_expected <= results_expected + 1;
                end
                m_s  <= 0;
                m_sx <= 0;
                m_sy <= 0;
            end else begin
                m_s  <= m_s + 32'(hit_l) + 32'(hit_r);
                m_sx <= m_sx + (hit_l ? 2 * m_col : 0) + (hit_r ? 2 * m_col + 1 : 0);
                m_sy <= m_sy + (hit_l ? m_row : 0) + (hit_r ? m_row : 0);
            end
            m_credits <= m_credits - int'(frame_end && credit_ok) + int'(credit_back);
        end
    end

    // ------------------------------------------------------------
    // UART decoder
    // ------------------------------------------------------------
    always @(posedge cclk) begin
        if (!rst_n) begin
            dec_busy     <= 1'b0;
            dec_cnt      <= 0;
            dec_shift    <= '0;
            byte_pos     <= 0;
            byte_done    <= 1'b0;
            res_done     <= 1'b0;
            exp_avail    <= 1'b0;
            results_seen <= 0;
        end else begin
            byte_done <= 1'b0;
            res_done  <= 1'b0;
            if (!dec_busy) begin
                if (!uart_txd) begin
                    dec_busy <= 1'b1;       // Start bit edge
                    dec_cnt  <= 1;
                end
            end else begin
                dec_cnt <= dec_cnt + 1;
                if (dec_cnt % uart_clks_per_bit == half_bit &&
                    dec_cnt > uart_clks_per_bit && dec_cnt < 9 * uart_clks_per_bit)
                    dec_shift <= {uart_txd, dec_shift[7:1]};   // Mid bit sample with LSB first
                if (dec_cnt == frame_clks - 1) begin
                    dec_busy  <= 1'b0;
                    byte_done <= 1'b1;
                    byte_val  <= dec_shift;
                    done_pos  <= byte_pos;
                    if (byte_pos != 0)
                        got_word.bytes[result_bytes - byte_pos] <= dec_shift;
                    if (byte_pos == result_bytes) begin
                        byte_pos     <= 0;
                        res_done     <= 1'b1;
                        results_seen <= results_seen + 1;
                        exp_avail    <= (exp_q.size() > 0);
                        if (exp_q.size() > 0)
                            exp_word <= exp_q.pop_front();
                    end else begin
                        byte_pos <= byte_pos + 1;
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------
    a_idle_after_reset: assert property (@(posedge cclk) disable iff (!rst_n)
        !frame_seen |-> uart_txd && !overrun)
        else begin
            err_cnt++;
            $error("FAILED %0t: UART or overrun active before the first frame end", $time);
        end

    a_start_bit: assert property (@(posedge cclk) disable iff (!rst_n)
        dec_busy && dec_cnt < uart_clks_per_bit |-> !uart_txd)
        else begin
            err_cnt++;
            $error("FAILED %0t: start bit ended early", $time);
        end

    a_stop_bit: assert property (@(posedge cclk) disable iff (!rst_n)
        dec_busy && dec_cnt >= 9 * uart_clks_per_bit |-> uart_txd)
        else begin
            err_cnt++;
            $error("FAILED %0t: stop bit is low", $time);
        end

    a_sync_first: assert property (@(posedge cclk) disable iff (!rst_n)
        byte_done && done_pos == 0 |-> byte_val == sync_byte)
        else begin
            err_cnt++;
            $error("FAILED %0t: result starts with %h, not the sync byte", $time, byte_val);
        end

    a_result_sums: assert property (@(posedge cclk) disable iff (!rst_n)
        res_done |-> exp_avail && got_word == exp_word)
        else begin
            err_cnt++;
            $error("FAILED %0t: result %h, expected %h (expected one: %0b)",
                   $time, got_word, exp_word, exp_avail);
        end

    // Overrun shows two cycles after the frame end sample
    a_overrun: assert property (@(posedge cclk) disable iff (!rst_n)
        overrun == $past(miss_now, 2))
        else begin
            err_cnt++;
            $error("FAILED %0t: overrun is %0b, model says %0b",
                   $time, overrun, $past(miss_now, 2));
        end

endmodule

bind eye_tracker_top eye_tracker_chk chk0 (.*);

/* test/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;    // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* source/eye_tracker_top.sv */
module eye_tracker_top (
    input  logic                                 cclk,
    input  logic                                 rst_n,
    input  logic                                 fval,
    input  logic                                 lval,
    input  logic                                 dval,
    input  logic [eye_tracker_pkg::pixel_w-1:0]  data_l,
    input  logic [eye_tracker_pkg::pixel_w-1:0]  data_r,
    input  logic [eye_tracker_pkg::pixel_w-1:0]  jp,       // Threshold jumpers
    output logic                                 uart_txd,
    output logic                                 overrun
);
    import eye_tracker_pkg::*;

    cam_beat_t    beat;
    logic         result_push;
    result_word_u result_data;
    logic         credit_return;
    logic         head_valid;
    result_word_u head_data;
    logic         pop;
    logic         tx_valid;
    logic [7:0]   tx_byte;
    logic         tx_ready;

    // ------------------------------------------------------------
    // Measurement path
    // ------------------------------------------------------------
    camera_link_rx m_camera_link_rx (
        .cclk   (cclk),
        .rst_n  (rst_n),
        .fval   (fval),
        .lval   (lval),
        .dval   (dval),
        .data_l (data_l),
        .data_r (data_r),
        .beat   (beat)
    );

    centroid_accum m_centroid_accum (
        .cclk          (cclk),
        .rst_n         (rst_n),
        .beat          (beat),
        .threshold     (jp),
        .credit_return (credit_return),
        .result_push   (result_push),
        .result_data   (result_data),
        .overrun       (overrun)
    );

    // Result queue and serial output
    result_fifo m_result_fifo (
        .cclk          (cclk),
        .rst_n         (rst_n),
        .push          (result_push),
        .push_data     (result_data),
        .pop           (pop),
        .head_valid    (head_valid),
        .head_data     (head_data),
        .credit_return (credit_return)
    );

    result_framer m_result_framer (
        .cclk       (cclk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head_data  (head_data),
        .tx_ready   (tx_ready),
        .pop        (pop),
        .tx_valid   (tx_valid),
        .tx_byte    (tx_byte)
    );

    uart_tx m_uart_tx (
        .cclk     (cclk),
        .rst_n    (rst_n),
        .tx_valid (tx_valid),
        .tx_byte  (tx_byte),
        .tx_ready (tx_ready),
        .txd      (uart_txd)
    );

endmodule

/* source/uart_tx.sv */
module uart_tx (
    input  logic        cclk,
    input  logic        rst_n,
    input  logic        tx_valid,
    input  logic [7:0]  tx_byte,
    output logic        tx_ready,
    output logic        txd
);
    import eye_tracker_pkg::*;

    logic                       busy;
    logic [uart_cnt_w-1:0]      clk_cnt;
    logic [uart_bit_w-1:0]      bit_cnt;
    logic [uart_frame_bits-1:0] shreg;
    logic                       bit_end;

    assign bit_end  = (clk_cnt == uart_cnt_w'(uart_clks_per_bit - 1));
    assign tx_ready = !busy;
    assign txd      = shreg[0];    // Line idles high through the ones shifted in

    // ------------------------------------------------------------
    // Frame shifter
    // ------------------------------------------------------------
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
            shreg   <= '1;
        end else if (!busy) begin
            if (tx_valid) begin
                busy    <= 1'b1;
                clk_cnt <= '0;
                bit_cnt <= '0;
                shreg   <= {1'b1, tx_byte, 1'b0};   // Stop, data, start
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            shreg   <= {1'b1, shreg[uart_frame_bits-1:1]};
            if (bit_cnt == uart_bit_w'(uart_frame_bits - 1))
                busy <= 1'b0;                      // Stop bit done
            else
                bit_cnt <= bit_cnt + 1'b1;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

/* source/result_framer.sv */
module result_framer (
    input  logic                           cclk,
    input  logic                           rst_n,
    input  logic                           head_valid,
    input  eye_tracker_pkg::result_word_u  head_data,
    input  logic                           tx_ready,
    output logic                           pop,
    output logic                           tx_valid,
    output logic [7:0]                     tx_byte
);
    import eye_tracker_pkg::*;

    logic                  active;
    logic [byte_idx_w-1:0] idx;        // 0 is the sync byte
    logic [byte_idx_w-1:0] byte_sel;
    logic                  accept;
    logic                  last;

    assign accept   = tx_valid && tx_ready;
    assign last     = (idx == byte_idx_w'(result_bytes));
    assign byte_sel = byte_idx_w'(result_bytes) - idx;   // 9 down to 0

    assign tx_valid = active;
    assign tx_byte  = (idx == '0) ? sync_byte : head_data.bytes[byte_sel];

    // Release the entry once byte 0 is taken
    assign pop = accept && last;

    // ------------------------------------------------------------
    // Byte sequencer
    // ------------------------------------------------------------
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            active <= 1'b0;
            idx    <= '0;
        end else if (!active) begin
            if (head_valid) begin
                active <= 1'b1;
                idx    <= '0;
            end
        end else if (accept) begin
            if (last) begin
                active <= 1'b0;
                idx    <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

/* source/result_fifo.sv */
module result_fifo (
    input  logic                           cclk,
    input  logic                           rst_n,
    input  logic                           push,
    input  eye_tracker_pkg::result_word_u  push_data,
    input  logic                           pop,
    output logic                           head_valid,
    output eye_tracker_pkg::result_word_u  head_data,
    output logic                           credit_return
);
    import eye_tracker_pkg::*;

    result_word_u        mem [result_depth];
    logic [fifo_ptr_w:0] wr_ptr;           // Top bit is the wrap flag
    logic [fifo_ptr_w:0] rd_ptr;
    logic                do_pop;

    // No full check here, the writer holds the credits
    assign head_valid = (wr_ptr != rd_ptr);
    assign head_data  = mem[rd_ptr[fifo_ptr_w-1:0]];
    assign do_pop     = pop && head_valid;

    // Storage
    always_ff @(posedge cclk) begin
        if (push) begin
            mem[wr_ptr[fifo_ptr_w-1:0]] <= push_data;
        end
    end

    // ------------------------------------------------------------
    // Pointers and credit return
    // ------------------------------------------------------------
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            credit_return <= do_pop;     // One credit per freed entry
        end
    end

endmodule

/* source/centroid_accum.sv */
module centroid_accum (
    input  logic                                 cclk,
    input  logic                                 rst_n,
    input  eye_tracker_pkg::cam_beat_t           beat,
    input  logic [eye_tracker_pkg::pixel_w-1:0]  threshold,
    input  logic                                 credit_return,
    output logic                                 result_push,
    output eye_tracker_pkg::result_word_u        result_data,
    output logic                                 overrun
);
    import eye_tracker_pkg::*;

    logic                hit_l;
    logic                hit_r;
    logic [1:0]          hits;
    logic [addr_w:0]     x_l;
    logic [addr_w:0]     x_r;
    logic [addr_w+1:0]   x_add;
    logic [addr_w:0]     y_add;
    logic [sum_s_w-1:0]  sum_s;
    logic [sum_sx_w-1:0] sum_sx;
    logic [sum_sy_w-1:0] sum_sy;
    logic [credit_w-1:0] credits;
    logic                has_credit;
    logic                spend;

    // ------------------------------------------------------------
    // Binarise and weight
    // ------------------------------------------------------------
    assign hit_l = beat.valid && (beat.pix_l >= threshold);
    assign hit_r = beat.valid && (beat.pix_r >= threshold);
    assign hits  = {1'b0, hit_l} + {1'b0, hit_r};

    assign x_l = {beat.col, 1'b0};         // Left pixel is the even x
    assign x_r = {beat.col, 1'b1};

    assign x_add = (hit_l ? {1'b0, x_l} : '0) + (hit_r ? {1'b0, x_r} : '0);
    assign y_add = (hit_l ? {1'b0, beat.row} : '0) + (hit_r ? {1'b0, beat.row} : '0);

    always_ff @(posedge cclk) begin
        if (!rst_n || beat.eof) begin
            sum_s  <= '0;
            sum_sx <= '0;
            sum_sy <= '0;
        end else if (beat.sof) begin
            // Fresh frame, drop anything left from a partial one
            sum_s  <= sum_s_w'(hits);
            sum_sx <= sum_sx_w'(x_add);
            sum_sy <= sum_sy_w'(y_add);
        end else if (beat.valid) begin
            sum_s  <= sum_s + sum_s_w'(hits);
            sum_sx <= sum_sx + sum_sx_w'(x_add);
            sum_sy <= sum_sy + sum_sy_w'(y_add);
        end
    end

    // ------------------------------------------------------------
    // Frame end, push or overrun
    // ------------------------------------------------------------
    assign has_credit = (credits != '0);
    assign spend      = beat.eof && has_credit;

    always_ff @(posedge cclk) begin
        if (beat.eof) begin
            result_data.sums <= '{pad: '0, sum_s: sum_s, sum_sx: sum_sx, sum_sy: sum_sy};
        end
        if (!rst_n) begin
            result_push <= 1'b0;
            overrun     <= 1'b0;
            credits     <= credit_w'(result_depth);
        end else begin
            result_push <= spend;
            overrun     <= beat.eof && !has_credit;   // Result is lost
            credits     <= credits - credit_w'(spend) + credit_w'(credit_return);
        end
    end

endmodule

/* source/camera_link_rx.sv */
module camera_link_rx (
    input  logic                                 cclk,
    input  logic                                 rst_n,
    input  logic                                 fval,
    input  logic                                 lval,
    input  logic                                 dval,
    input  logic [eye_tracker_pkg::pixel_w-1:0]  data_l,
    input  logic [eye_tracker_pkg::pixel_w-1:0]  data_r,
    output eye_tracker_pkg::cam_beat_t           beat
);
    import eye_tracker_pkg::*;

    logic              fval_a;
    logic              lval_a;
    logic              dval_a;
    logic              fval_q;
    logic              lval_q;
    logic              pix_ok;
    logic              fval_rise;
    logic              fval_fall;
    logic              lval_fall;
    logic              sof_pending;
    logic [addr_w-1:0] col_cnt;
    logic [addr_w-1:0] row_cnt;

    // Normalise to active high
    assign fval_a = (fval == fval_pol);
    assign lval_a = (lval == lval_pol);
    assign dval_a = (dval == dval_pol);

    assign pix_ok    = fval_a && lval_a && dval_a;
    assign fval_rise = !fval_q && fval_a;
    assign fval_fall = fval_q && !fval_a;
    assign lval_fall = lval_q && !lval_a;

    // ------------------------------------------------------------
    // Edge history and position counters
    // ------------------------------------------------------------
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            fval_q      <= 1'b0;
            lval_q      <= 1'b0;
            col_cnt     <= '0;
            row_cnt     <= '0;
            sof_pending <= 1'b0;
        end else begin
            fval_q <= fval_a;
            lval_q <= lval_a;

            if (!lval_a)
                col_cnt <= '0;               // New line starts at pair 0
            else if (pix_ok)
                col_cnt <= col_cnt + 1'b1;

            if (!fval_a)
                row_cnt <= '0;
            else if (lval_fall)
                row_cnt <= row_cnt + 1'b1;   // Line done

            if (pix_ok)
                sof_pending <= 1'b0;
            else if (fval_rise)
                sof_pending <= 1'b1;
        end
    end

    // Output beat, one cycle after the pins
    always_ff @(posedge cclk) begin
        beat.col   <= col_cnt;
        beat.row   <= row_cnt;
        beat.pix_l <= data_l;
        beat.pix_r <= data_r;
        if (!rst_n) begin
            beat.valid <= 1'b0;
            beat.sof   <= 1'b0;
            beat.eof   <= 1'b0;
        end else begin
            beat.valid <= pix_ok;
            beat.sof   <= pix_ok && (sof_pending || fval_rise);
            beat.eof   <= fval_fall;
        end
    end

endmodule

/* source/eye_tracker_pkg.sv */
package eye_tracker_pkg;

    // ------------------------------------------------------------
    // Widths and sizes
    // ------------------------------------------------------------
    localparam int pixel_w  = 8;
    localparam int addr_w   = 10;        // Column and row counters
    localparam int sum_s_w  = 20;
    localparam int sum_sx_w = 28;
    localparam int sum_sy_w = 28;

    localparam int result_bytes = 10;
    localparam int result_pad_w = result_bytes * 8 - sum_s_w - sum_sx_w - sum_sy_w;
    localparam int result_depth = 2;     // Queue entries and initial credits

    localparam int credit_w   = $clog2(result_depth + 1);
    localparam int fifo_ptr_w = $clog2(result_depth);
    localparam int byte_idx_w = $clog2(result_bytes + 1);

    // UART framing, 8N1
    localparam int         uart_clks_per_bit = 16;
    localparam int         uart_cnt_w        = $clog2(uart_clks_per_bit);
    localparam int         uart_frame_bits   = 10;   // Start, eight data, stop
    localparam int         uart_bit_w        = $clog2(uart_frame_bits);
    localparam logic [7:0] sync_byte         = 8'ha5;

    // Camera Link polarities
    localparam logic fval_pol = 1'b1;
    localparam logic lval_pol = 1'b1;
    localparam logic dval_pol = 1'b0;    // Camera drives data valid active low

    // ------------------------------------------------------------
    // Types
    // ------------------------------------------------------------
    typedef struct packed {
        logic               valid;
        logic               sof;     // First pixel beat of the frame
        logic               eof;     // Frame end marker, no pixels
        logic [addr_w-1:0]  col;     // Pair index within the line
        logic [addr_w-1:0]  row;
        logic [pixel_w-1:0] pix_l;
        logic [pixel_w-1:0] pix_r;
    } cam_beat_t;

    typedef struct packed {
        logic [result_pad_w-1:0] pad;
        logic [sum_s_w-1:0]      sum_s;
        logic [sum_sx_w-1:0]     sum_sx;
        logic [sum_sy_w-1:0]     sum_sy;
    } centroid_sums_t;

    // Byte 9 is the most significant, sent first after sync
    typedef union packed {
        centroid_sums_t                sums;
        logic [result_bytes-1:0][7:0] bytes;
    } result_word_u;

endpackage
